//--- source/fetch_pkg.sv
// Fetch subsystem package: data widths, cache geometry and vector types
`default_nettype none

package fetch_pkg;

  // Datapath widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned LINE_W     = LINE_WORDS * XLEN;

  // Cache geometry
  localparam int unsigned NUM_WAYS = 2;
  localparam int unsigned NUM_SETS = 16;

  // Address split: tag | index | byte offset
  localparam int unsigned OFFSET_W = 4;
  localparam int unsigned INDEX_W  = 4;
  localparam int unsigned TAG_W    = XLEN - INDEX_W - OFFSET_W;

  // Fetch address
  typedef logic [XLEN-1:0] addr_t;

  // One full cache line
  typedef logic [LINE_W-1:0] line_t;

  // Stored tag
  typedef logic [TAG_W-1:0] tag_t;

  // Set index
  typedef logic [INDEX_W-1:0] index_t;

  // One bit per way, for hits and victim selection
  typedef logic [NUM_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

//--- source/fetch_req_ctrl.sv
// Fetch request controller: PC to address handshake, line back to the fetch stage
`default_nettype none

module fetch_req_ctrl (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  // Fetch stage side
  input  fetch_pkg::addr_t pc_i,
  input  logic             read_req_i,
  output fetch_pkg::line_t line_o,
  output logic             read_done_o,
  // Cache side
  output fetch_pkg::addr_t addr_o,
  output logic             addr_valid_o,
  input  logic             addr_ready_i,
  input  fetch_pkg::line_t line_i,
  input  logic             data_valid_i,
  output logic             data_ready_o
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {
    RESET,
    WAIT_REQ,
    ADDR_BUSY,
    WAIT_DATA
  } state_t;

  state_t state_q, state_d;
  addr_t  saved_pc_q;
  logic   addr_sel;

  // Capture PC only when it is put on the bus, not while a saved one waits
  always_ff @(posedge clk_i) begin
    if (addr_valid_o && !addr_sel) begin
      saved_pc_q <= pc_i;
    end
  end

  // Live PC on a fresh request, saved PC while stalled
  assign addr_o = addr_sel ? saved_pc_q : pc_i;

  // Line goes straight through to the fetch stage
  assign line_o = line_i;

  // State register, flush overrides everything
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RESET;
    end else if (flush_i) begin
      state_q <= WAIT_REQ;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET: begin
        state_d = WAIT_REQ;
      end
      WAIT_REQ: begin
        if (read_req_i) begin
          state_d = addr_ready_i ? WAIT_DATA : ADDR_BUSY;
        end
      end
      // Holds the request so read_req_i may drop early
      ADDR_BUSY: begin
        if (addr_ready_i) begin
          state_d = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (data_valid_i) begin
          if (!read_req_i) begin
            state_d = WAIT_REQ;
          end else begin
            // Next request chained onto the completing one
            state_d = addr_ready_i ? WAIT_DATA : ADDR_BUSY;
          end
        end
      end
      default: begin
        state_d = RESET;
      end
    endcase
  end

  // Outputs
  always_comb begin
    addr_valid_o = 1'b0;
    data_ready_o = 1'b0;
    read_done_o  = 1'b0;
    addr_sel     = 1'b0;
    case (state_q)
      WAIT_REQ: begin
        addr_valid_o = read_req_i;
      end
      ADDR_BUSY: begin
        addr_valid_o = 1'b1;
        addr_sel     = 1'b1;
      end
      WAIT_DATA: begin
        data_ready_o = 1'b1;
        read_done_o  = data_valid_i;
        addr_valid_o = data_valid_i && read_req_i;
      end
      default: begin
        addr_valid_o = 1'b0;
      end
    endcase
  end

  // A stalled address must not move until the cache takes it
  a_addr_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (addr_valid_o && !addr_ready_i && !flush_i) |=> $stable(addr_o)
  );

endmodule

`default_nettype wire

//--- source/icache_way.sv
// Instruction cache way: tag, valid and line storage with registered lookup
`default_nettype none

module icache_way (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              lookup_i,
  input  fetch_pkg::index_t index_i,
  input  fetch_pkg::tag_t   tag_i,
  input  logic              fill_i,
  input  logic              fill_sel_i,
  input  fetch_pkg::line_t  fill_line_i,
  input  logic              inval_all_i,
  output logic              hit_o,
  output fetch_pkg::line_t  rd_line_o
);

  import fetch_pkg::*;

  tag_t                tag_mem  [NUM_SETS];
  line_t               line_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;

  // Read-side registers, one cycle behind the strobe
  logic  rd_valid_q;
  tag_t  rd_tag_q;
  tag_t  req_tag_q;
  line_t rd_line_q;

  logic  do_fill;

  assign do_fill = fill_i && fill_sel_i;

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else if (inval_all_i) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (do_fill) begin
        valid_q[index_i] <= 1'b1;
      end
      if (lookup_i) begin
        rd_valid_q <= valid_q[index_i];
      end
    end
  end

  // Tag and line arrays
  always_ff @(posedge clk_i) begin
    if (do_fill) begin
      tag_mem[index_i]  <= tag_i;
      line_mem[index_i] <= fill_line_i;
    end
    if (lookup_i) begin
      rd_tag_q  <= tag_mem[index_i];
      rd_line_q <= line_mem[index_i];
      req_tag_q <= tag_i;
    end
  end

  // Compare against the tag that was looked up
  assign hit_o     = rd_valid_q && (rd_tag_q == req_tag_q);
  assign rd_line_o = rd_line_q;

endmodule

`default_nettype wire

//--- source/icache_lookup_ctrl.sv
// Instruction cache controller: address accept, lookup, miss refill, victim choice
`default_nettype none

module icache_lookup_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // From the request controller
  input  fetch_pkg::addr_t     addr_i,
  input  logic                 addr_valid_i,
  output logic                 addr_ready_o,
  // From the way selector
  input  logic                 miss_i,
  input  logic                 resp_free_i,
  // To every way
  output logic                 lookup_o,
  output fetch_pkg::index_t    index_o,
  output fetch_pkg::tag_t      tag_o,
  output logic                 fill_o,
  output fetch_pkg::way_mask_t fill_way_o,
  output fetch_pkg::line_t     fill_line_o,
  output logic                 inval_all_o,
  // Memory port
  output logic                 mem_req_o,
  output fetch_pkg::addr_t     mem_addr_o,
  input  logic                 mem_valid_i,
  input  fetch_pkg::line_t     mem_line_i
);

  import fetch_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    REPLAY,
    RESPOND
  } state_t;

  state_t    state_q, state_d;
  addr_t     addr_q;
  addr_t     lk_addr;
  index_t    cur_index;
  logic      accept;
  logic      pend_q;
  way_mask_t rr_q [NUM_SETS];

  // Ready in IDLE, or in RESPOND while the response drains
  assign addr_ready_o = !flush_i && !pend_q &&
                        ((state_q == IDLE) || ((state_q == RESPOND) && resp_free_i));
  assign accept       = addr_valid_i && addr_ready_o;

  // New address on accept, otherwise the latched one
  assign lk_addr   = accept ? addr_i : addr_q;
  assign index_o   = lk_addr[OFFSET_W +: INDEX_W];
  assign tag_o     = lk_addr[XLEN-1 -: TAG_W];
  assign cur_index = addr_q[OFFSET_W +: INDEX_W];

  assign lookup_o = accept || ((state_q == REPLAY) && !flush_i);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= addr_i;
    end
  end

  // Refill datapath
  assign fill_o      = (state_q == REFILL) && mem_valid_i && !flush_i;
  assign fill_way_o  = rr_q[cur_index];
  assign fill_line_o = mem_line_i;
  assign inval_all_o = flush_i;

  // Request held across a flush until memory answers
  assign mem_req_o  = (state_q == REFILL) || pend_q;
  assign mem_addr_o = {addr_q[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // Per-set round-robin victim pointer, one-hot
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_q[s] <= way_mask_t'(1);
      end
    end else if (fill_o) begin
      rr_q[cur_index] <= {rr_q[cur_index][NUM_WAYS-2:0], rr_q[cur_index][NUM_WAYS-1]};
    end
  end

  // Outstanding refill that a flush orphaned
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
    end else if (mem_valid_i) begin
      pend_q <= 1'b0;
    end else if (flush_i && (state_q == REFILL)) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else if (flush_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = LOOKUP;
        end
      end
      // Way results are valid here
      LOOKUP: begin
        state_d = miss_i ? REFILL : RESPOND;
      end
      REFILL: begin
        if (mem_valid_i) begin
          state_d = REPLAY;
        end
      end
      // Lookup again, the filled line now hits
      REPLAY: begin
        state_d = LOOKUP;
      end
      RESPOND: begin
        if (resp_free_i) begin
          state_d = accept ? LOOKUP : IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  a_fill_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fill_o |-> $onehot(fill_way_o)
  );

endmodule

`default_nettype wire

//--- source/icache_way_select.sv
// Way selector: hit merge, response register and miss report
`default_nettype none

module icache_way_select (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         flush_i,
  input  logic                                         lookup_done_i,
  input  fetch_pkg::way_mask_t                         hit_i,
  input  fetch_pkg::line_t [fetch_pkg::NUM_WAYS-1:0]   way_line_i,
  input  logic                                         data_ready_i,
  output logic                                         miss_o,
  output logic                                         resp_free_o,
  output fetch_pkg::line_t                             line_o,
  output logic                                         data_valid_o
);

  import fetch_pkg::*;

  logic  result_q;
  logic  any_hit;
  logic  valid_q;
  line_t hit_line;
  line_t line_q;

  // AND-OR merge, at most one way hits
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_i[w]) begin
        hit_line = hit_line | way_line_i[w];
      end
    end
  end

  assign any_hit = |hit_i;

  // Ways answer one cycle after the strobe
  assign miss_o = result_q && !any_hit;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_q <= 1'b0;
      valid_q  <= 1'b0;
    end else if (flush_i) begin
      result_q <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      result_q <= lookup_done_i;
      if (result_q && any_hit) begin
        valid_q <= 1'b1;
      end else if (valid_q && data_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (result_q && any_hit) begin
      line_q <= hit_line;
    end
  end

  // Empty or draining this cycle
  assign resp_free_o  = !valid_q || data_ready_i;
  assign data_valid_o = valid_q;
  assign line_o       = line_q;

  a_hit_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(hit_i)
  );

endmodule

`default_nettype wire

//--- source/fetch_top.sv
// Fetch subsystem top: request controller, cache controller, ways and way selector
`default_nettype none

module fetch_top (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  // Fetch stage
  input  fetch_pkg::addr_t pc_i,
  input  logic             read_req_i,
  output fetch_pkg::line_t line_o,
  output logic             read_done_o,
  // External memory
  output logic             mem_req_o,
  output fetch_pkg::addr_t mem_addr_o,
  input  logic             mem_valid_i,
  input  fetch_pkg::line_t mem_line_i
);

  import fetch_pkg::*;

  // Address and data handshakes
  addr_t addr;
  logic  addr_valid;
  logic  addr_ready;
  line_t sel_line;
  logic  data_valid;
  logic  data_ready;

  // Way control, shared by all ways
  logic      lookup;
  index_t    index;
  tag_t      tag;
  logic      fill;
  way_mask_t fill_way;
  line_t     fill_line;
  logic      inval_all;

  // Way results
  way_mask_t               hit;
  line_t [NUM_WAYS-1:0]    way_line;
  logic                    miss;
  logic                    resp_free;

  fetch_req_ctrl u_req_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .pc_i         (pc_i),
    .read_req_i   (read_req_i),
    .line_o       (line_o),
    .read_done_o  (read_done_o),
    .addr_o       (addr),
    .addr_valid_o (addr_valid),
    .addr_ready_i (addr_ready),
    .line_i       (sel_line),
    .data_valid_i (data_valid),
    .data_ready_o (data_ready)
  );

  icache_lookup_ctrl u_lookup_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .addr_i       (addr),
    .addr_valid_i (addr_valid),
    .addr_ready_o (addr_ready),
    .miss_i       (miss),
    .resp_free_i  (resp_free),
    .lookup_o     (lookup),
    .index_o      (index),
    .tag_o        (tag),
    .fill_o       (fill),
    .fill_way_o   (fill_way),
    .fill_line_o  (fill_line),
    .inval_all_o  (inval_all),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_valid_i  (mem_valid_i),
    .mem_line_i   (mem_line_i)
  );

  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    icache_way u_way (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .lookup_i    (lookup),
      .index_i     (index),
      .tag_i       (tag),
      .fill_i      (fill),
      .fill_sel_i  (fill_way[g]),
      .fill_line_i (fill_line),
      .inval_all_i (inval_all),
      .hit_o       (hit[g]),
      .rd_line_o   (way_line[g])
    );
  end

  icache_way_select u_way_select (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .lookup_done_i (lookup),
    .hit_i         (hit),
    .way_line_i    (way_line),
    .data_ready_i  (data_ready),
    .miss_o        (miss),
    .resp_free_o   (resp_free),
    .line_o        (sel_line),
    .data_valid_o  (data_valid)
  );

endmodule

`default_nettype wire

//--- test/fetch_checker.sv
// Testbench checker: reference line, model cache with round-robin victims, request compares
`default_nettype none

module fetch_checker (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  int               test_id_i,
  input  fetch_pkg::addr_t pc_i,
  input  logic             read_req_i,
  input  fetch_pkg::addr_t addr_i,
  input  logic             addr_valid_i,
  input  logic             addr_ready_i,
  input  logic             read_done_i,
  input  fetch_pkg::line_t line_i,
  input  logic             mem_req_i,
  input  fetch_pkg::addr_t mem_addr_i,
  input  logic             mem_valid_i,
  output int               mismatch_cnt_o,
  output int               other_err_cnt_o,
  output int               pending_o
);

  import fetch_pkg::*;

  // Model cache
  tag_t  model_tag   [NUM_WAYS][NUM_SETS];
  logic  model_valid [NUM_WAYS][NUM_SETS];
  int    victim      [NUM_SETS];
  // Accepted requests in order
  addr_t req_addr_q [$];
  logic  req_hit_q  [$];
  int    req_cyc_q  [$];
  int    cycle      = 0;
  int    mismatches = 0;
  int    other_errs = 0;
  // Refill the model expects for the current miss
  logic  refill_exp  = 1'b0;
  logic  refill_seen = 1'b0;
  logic  mem_req_q   = 1'b0;
  addr_t refill_addr = '0;
  // Fetch side request and the PC it should put on the address bus
  logic  fe_busy     = 1'b0;
  logic  fe_addr_exp = 1'b0;
  addr_t fe_pc       = '0;

  // Each 32-bit word is a hash of its word address
  function automatic line_t expected_line(addr_t addr);
    line_t line;
    addr_t waddr;
    for (int i = 0; i < LINE_WORDS; i++) begin
      waddr = ({addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}} >> 2) + addr_t'(i);
      line[i*XLEN +: XLEN] = (waddr * 32'h9E37_79B1) ^ {waddr[15:0], waddr[31:16]} ^ 32'h0F1E_2D3C;
    end
    return line;
  endfunction

  function automatic logic model_hit(addr_t addr);
    index_t idx;
    logic   hit;
    idx = addr[OFFSET_W +: INDEX_W];
    hit = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (model_valid[w][idx] && (model_tag[w][idx] == addr[XLEN-1 -: TAG_W])) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic string test_label(int id);
    case (id)
      1: return "single_random";
      2: return "repeat_hit";
      3: return "set_conflict";
      4: return "back_to_back";
      5: return "pulse_while_busy";
      6: return "flush_refetch";
      default: return "setup";
    endcase
  endfunction

  always @(posedge clk_i) begin
    index_t idx;
    addr_t  a;
    logic   hit;
    int     acc_cyc;
    if (!rst_n_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        victim[s] = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          model_valid[w][s] = 1'b0;
        end
      end
      req_addr_q.delete();
      req_hit_q.delete();
      req_cyc_q.delete();
      refill_exp  = 1'b0;
      mem_req_q   = 1'b0;
      fe_busy     = 1'b0;
      fe_addr_exp = 1'b0;
    end else begin
      cycle++;
      // Completion, oldest request first
      if (read_done_i) begin
        if (req_addr_q.size() == 0) begin
          $display("ERROR %s: read_done_o with no request outstanding", test_label(test_id_i));
          other_errs++;
        end else begin
          a       = req_addr_q.pop_front();
          hit     = req_hit_q.pop_front();
          acc_cyc = req_cyc_q.pop_front();
          if (line_i !== expected_line(a)) begin
            $display("MISMATCH %s: line of %h expected %h actual %h",
                     test_label(test_id_i), a, expected_line(a), line_i);
            mismatches++;
          end
          if (hit && (cycle - acc_cyc != 2)) begin
            $display("MISMATCH %s: hit latency of %h expected %0d actual %0d",
                     test_label(test_id_i), a, 2, cycle - acc_cyc);
            mismatches++;
          end
          if (!hit) begin
            if (!refill_seen) begin
              $display("ERROR %s: miss on %h finished without a memory request",
                       test_label(test_id_i), a);
              other_errs++;
            end
            refill_exp = 1'b0;
          end
        end
      end
      // Exactly one memory request per predicted miss
      if (mem_req_i && !mem_req_q) begin
        if (!refill_exp || refill_seen) begin
          $display("ERROR %s: memory request for %h that the model cache does not expect",
                   test_label(test_id_i), mem_addr_i);
          other_errs++;
        end else begin
          if (mem_addr_i !== refill_addr) begin
            $display("MISMATCH %s: refill address expected %h actual %h",
                     test_label(test_id_i), refill_addr, mem_addr_i);
            mismatches++;
          end
          refill_seen = 1'b1;
        end
      end
      mem_req_q = mem_req_i;
      // Fill lands in the round-robin victim unless flushed
      if (mem_valid_i && refill_exp && refill_seen && !flush_i) begin
        idx = refill_addr[OFFSET_W +: INDEX_W];
        model_tag[victim[idx]][idx]   = refill_addr[XLEN-1 -: TAG_W];
        model_valid[victim[idx]][idx] = 1'b1;
        victim[idx] = (victim[idx] + 1) % NUM_WAYS;
      end
      // Fetch side takes a PC when idle or when its current line completes
      if ((!fe_busy || read_done_i) && !flush_i) begin
        fe_busy = read_req_i;
        if (read_req_i) begin
          fe_pc       = pc_i;
          fe_addr_exp = 1'b1;
        end
      end
      if (addr_valid_i && addr_ready_i) begin
        if (!fe_addr_exp) begin
          $display("ERROR %s: address handshake with no fetch request behind it",
                   test_label(test_id_i));
          other_errs++;
        end else if (addr_i !== fe_pc) begin
          $display("MISMATCH %s: request address expected %h actual %h",
                   test_label(test_id_i), fe_pc, addr_i);
          mismatches++;
        end
        fe_addr_exp = 1'b0;
        a   = {addr_i[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
        hit = model_hit(a);
        req_addr_q.push_back(a);
        req_hit_q.push_back(hit);
        req_cyc_q.push_back(cycle);
        if (!hit) begin
          refill_exp  = 1'b1;
          refill_seen = 1'b0;
          refill_addr = a;
        end
      end
      // Flush drops open requests and all valid lines, victims keep their place
      if (flush_i) begin
        req_addr_q.delete();
        req_hit_q.delete();
        req_cyc_q.delete();
        refill_exp  = 1'b0;
        fe_busy     = 1'b0;
        fe_addr_exp = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
          for (int w = 0; w < NUM_WAYS; w++) begin
            model_valid[w][s] = 1'b0;
          end
        end
      end
    end
    mismatch_cnt_o  <= mismatches;
    other_err_cnt_o <= other_errs;
    pending_o       <= req_addr_q.size();
  end

endmodule

`default_nettype wire

//--- test/fetch_tb.sv
// Testbench top for the fetch subsystem: clock, reset, memory model, stimulus, timeout, report
`default_nettype none

module fetch_tb;

  import fetch_pkg::*;

  // About 650 requests, a miss costs at most about 15 cycles
  localparam int REQ_BUDGET     = 700;
  localparam int TIMEOUT_CYCLES = REQ_BUDGET * 15 + 1500;
  localparam int POOL_SIZE      = 16;
  // Tag order for the set conflict test
  localparam int CONFLICT_SEQ [7] = '{0, 1, 0, 2, 0, 1, 2};

  logic  clk_i       = 1'b0;
  logic  rst_n_i     = 1'b0;
  logic  flush_i     = 1'b0;
  addr_t pc_i        = '0;
  logic  read_req_i  = 1'b0;
  logic  mem_valid_i = 1'b0;
  line_t mem_line_i  = '0;
  line_t line_o;
  logic  read_done_o;
  logic  mem_req_o;
  addr_t mem_addr_o;

  int    test_id    = 0;
  int    cycles     = 0;
  int    mismatches;
  int    other_errors;
  int    pending;
  // Memory model state
  logic  mem_busy   = 1'b0;
  int    mem_wait   = 0;
  addr_t mem_addr_q = '0;
  // Lines that get reused across tests
  addr_t pool [POOL_SIZE];

  fetch_top dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .pc_i        (pc_i),
    .read_req_i  (read_req_i),
    .line_o      (line_o),
    .read_done_o (read_done_o),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_valid_i (mem_valid_i),
    .mem_line_i  (mem_line_i)
  );

  // Address handshake is internal, taken from the DUT hierarchy
  fetch_checker chk0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .test_id_i       (test_id),
    .pc_i            (pc_i),
    .read_req_i      (read_req_i),
    .addr_i          (dut0.addr),
    .addr_valid_i    (dut0.addr_valid),
    .addr_ready_i    (dut0.addr_ready),
    .read_done_i     (read_done_o),
    .line_i          (line_o),
    .mem_req_i       (mem_req_o),
    .mem_addr_i      (mem_addr_o),
    .mem_valid_i     (mem_valid_i),
    .mismatch_cnt_o  (mismatches),
    .other_err_cnt_o (other_errors),
    .pending_o       (pending)
  );

  always #5 clk_i = ~clk_i;

  // Memory contents, each word a hash of its word address
  function automatic line_t mem_line(addr_t addr);
    line_t line;
    addr_t waddr;
    for (int i = 0; i < LINE_WORDS; i++) begin
      waddr = ({addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}} >> 2) + addr_t'(i);
      line[i*XLEN +: XLEN] = (waddr * 32'h9E37_79B1) ^ {waddr[15:0], waddr[31:16]} ^ 32'h0F1E_2D3C;
    end
    return line;
  endfunction

  // Random word address below the region kept for fresh lines
  function automatic addr_t rand_addr();
    return $urandom() & 32'h7FFF_FFFC;
  endfunction

  // Answer after 1 to 5 cycles, one-cycle valid pulse
  always @(posedge clk_i) begin
    int delay;
    mem_valid_i <= 1'b0;
    if (mem_busy) begin
      if (mem_wait <= 1) begin
        mem_valid_i <= 1'b1;
        mem_line_i  <= mem_line(mem_addr_q);
        mem_busy    <= 1'b0;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (mem_req_o && !mem_valid_i) begin
      delay = 1 + $urandom_range(0, 4);
      // Shortest delay answers in the cycle right after the request
      if (delay == 1) begin
        mem_valid_i <= 1'b1;
        mem_line_i  <= mem_line(mem_addr_o);
      end else begin
        mem_busy   <= 1'b1;
        mem_wait   <= delay - 1;
        mem_addr_q <= mem_addr_o;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, requests stopped completing", cycles);
      $display("sim failed");
      $finish;
    end
  end

  task automatic wait_done();
    do begin
      @(posedge clk_i);
    end while (!read_done_o);
  endtask

  // Wait until the checker holds no open request
  task automatic drain();
    do begin
      @(posedge clk_i);
    end while (pending != 0);
  endtask

  // One-cycle request pulse, then wait for its line
  task automatic single_read(addr_t addr);
    pc_i       <= addr;
    read_req_i <= 1'b1;
    @(posedge clk_i);
    read_req_i <= 1'b0;
    wait_done();
  endtask

  initial begin
    addr_t  a;
    tag_t   tags [3];
    index_t idx;
    int     done_cnt;
    void'($urandom(32'h88F7));
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = rand_addr();
    end
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    // Random singles, half of them from the pool
    test_id <= 1;
    repeat (150) begin
      single_read(($urandom_range(0, 1) == 0) ? rand_addr() : pool[$urandom_range(0, 15)]);
    end

    // First touch then repeats in the same line
    test_id <= 2;
    repeat (20) begin
      a = rand_addr();
      single_read(a);
      single_read(a);
      single_read(a ^ 32'h0000_0008);
    end

    // Three tags fighting over one set
    test_id <= 3;
    repeat (10) begin
      idx = index_t'($urandom());
      for (int t = 0; t < 3; t++) begin
        tags[t] = tag_t'($urandom() & 32'h007F_FFFF);
      end
      for (int k = 0; k < 7; k++) begin
        single_read({tags[CONFLICT_SEQ[k]], idx, {OFFSET_W{1'b0}}});
      end
    end

    // Request held high, PC moves every cycle
    test_id    <= 4;
    done_cnt   = 0;
    pc_i       <= pool[0];
    read_req_i <= 1'b1;
    while (done_cnt < 250) begin
      @(posedge clk_i);
      pc_i <= ($urandom_range(0, 3) == 0) ? rand_addr() : pool[$urandom_range(0, 15)];
      if (read_done_o) begin
        done_cnt++;
      end
    end
    read_req_i <= 1'b0;
    drain();

    for (int r = 0; r < 6; r++) begin
      test_id <= 5;
      single_read(pool[r]);
      // Fresh line so the refill is certain, flushed mid refill
      pc_i       <= 32'hF000_0000 + addr_t'(r * 16);
      read_req_i <= 1'b1;
      @(posedge clk_i);
      read_req_i <= 1'b0;
      do begin
        @(posedge clk_i);
      end while (!mem_req_o);
      flush_i <= 1'b1;
      @(posedge clk_i);
      flush_i    <= 1'b0;
      pc_i       <= pool[r];
      read_req_i <= 1'b1;
      // Short pulse while the orphaned refill is still out
      @(posedge clk_i);
      read_req_i <= 1'b0;
      pc_i       <= rand_addr();
      wait_done();
      // Everything cached before the flush has to miss
      test_id <= 6;
      for (int i = 0; i < POOL_SIZE; i++) begin
        single_read(pool[i]);
      end
    end

    repeat (5) @(posedge clk_i);
    if (pending != 0) begin
      $display("Run ended with %0d requests that never completed", pending);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0 && pending == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
source/fetch_pkg.sv
source/fetch_req_ctrl.sv
source/icache_way.sv
source/icache_lookup_ctrl.sv
source/icache_way_select.sv
source/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f verilog.f \
  --top-module fetch_tb \
  -Mdir obj_dir

./obj_dir/Vfetch_tb > "$LOG" 2>&1
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
